/* sim.f */
logic/md_data_pkg.sv
logic/md_regs_pkg.sv
logic/pos_bank.sv
logic/pos_cache_ctrl.sv
logic/cell_cfg_axil.sv
logic/pos_cache_cell.sv
verif/pos_cache_checker.sv
verif/pos_cache_tb.sv

/* verif/pos_cache_tb.sv */
// Testbench driving random motion updates, cache reads and register traffic
`timescale 1ns/1ns

module pos_cache_tb;

	localparam int PARTICLE_NUM = 16;
	localparam int ADDR_WIDTH = 5;
	// Worst cycles of one register access with ready forced after three stalls
	localparam int AXI_OP = 10;
	// Two idle cycles plus one read per address and a trailing cycle
	localparam int SCAN = PARTICLE_NUM + 4;
	localparam int T1_LEN = 9 * AXI_OP + 2;
	localparam int T2_LEN = 32 + SCAN + AXI_OP + 2;
	localparam int T3_LEN = 22 + SCAN + 2;
	localparam int T4_LEN = 26 + SCAN + 4 * AXI_OP + 2;
	localparam int T5_LEN = 6 + 2 + 6 * AXI_OP + 2;
	localparam int CYCLE_LIMIT = 2 * (8 + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN);

	logic clk;
	logic rst;
	logic motion_update_enable;
	md_data_pkg::pos_t in_data;
	md_data_pkg::cell_addr_t in_data_dst_cell;
	logic in_data_valid;
	logic in_rden;
	logic [ADDR_WIDTH-1:0] in_read_address;
	md_data_pkg::pos_t out_particle_info;
	md_regs_pkg::axi_addr_t s_awaddr;
	logic s_awvalid;
	logic s_awready;
	md_regs_pkg::axi_data_t s_wdata;
	logic s_wvalid;
	logic s_wready;
	md_regs_pkg::axi_resp_t s_bresp;
	logic s_bvalid;
	logic s_bready;
	md_regs_pkg::axi_addr_t s_araddr;
	logic s_arvalid;
	logic s_arready;
	md_regs_pkg::axi_data_t s_rdata;
	md_regs_pkg::axi_resp_t s_rresp;
	logic s_rvalid;
	logic s_rready;
	int err_count;
	int check_count;
	integer seed;
	// Cell id last written, used to aim arrivals
	md_data_pkg::cell_addr_t cur_cell;
	int cycles = 0;
	int tests_run;
	int tests_failed;
	int err_mark;
	int chk_mark;

	pos_cache_cell #(
		.PARTICLE_NUM(PARTICLE_NUM),
		.ADDR_WIDTH(ADDR_WIDTH)
	) dut (.*);

	pos_cache_checker #(
		.PARTICLE_NUM(PARTICLE_NUM),
		.ADDR_WIDTH(ADDR_WIDTH)
	) chk (.*);

	always #10 clk = ~clk;

	// Watchdog on the whole run
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the run did not reach its end", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	task write_reg(input md_regs_pkg::axi_addr_t addr, input md_regs_pkg::axi_data_t data);
		int waited;
		s_awaddr = addr;
		s_wdata = data;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		@(posedge clk);
		while (!s_awready)
			@(posedge clk);
		@(negedge clk);
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		// Random stalls on bready until three have passed
		waited = 0;
		s_bready = ($random(seed) & 1) != 0;
		@(posedge clk);
		while (!(s_bvalid && s_bready))
		begin
			@(negedge clk);
			waited++;
			s_bready = (($random(seed) & 1) != 0) || (waited >= 3);
			@(posedge clk);
		end
		@(negedge clk);
		s_bready = 1'b0;
	endtask

	task read_reg(input md_regs_pkg::axi_addr_t addr);
		int waited;
		s_araddr = addr;
		s_arvalid = 1'b1;
		@(posedge clk);
		while (!s_arready)
			@(posedge clk);
		@(negedge clk);
		s_arvalid = 1'b0;
		waited = 0;
		s_rready = ($random(seed) & 1) != 0;
		@(posedge clk);
		while (!(s_rvalid && s_rready))
		begin
			@(negedge clk);
			waited++;
			s_rready = (($random(seed) & 1) != 0) || (waited >= 3);
			@(posedge clk);
		end
		@(negedge clk);
		s_rready = 1'b0;
	endtask

	// One update of n arrivals with match_pct percent aimed at this cell
	task run_update(input int n, input int match_pct);
		md_data_pkg::cell_addr_t other;
		motion_update_enable = 1'b1;
		in_data_valid = 1'b0;
		@(negedge clk);
		for (int i = 0; i < n; i++)
		begin
			other = md_data_pkg::cell_addr_t'($random(seed));
			if (other == cur_cell)
				other = other ^ 12'h001;
			in_data_valid = 1'b1;
			in_data = {$random(seed), $random(seed), $random(seed)};
			if ($unsigned($random(seed)) % 100 < match_pct)
				in_data_dst_cell = cur_cell;
			else
				in_data_dst_cell = other;
			// Active bank reads alongside the fill
			in_rden = ($random(seed) & 1) != 0;
			in_read_address = ADDR_WIDTH'($unsigned($random(seed)) % (PARTICLE_NUM + 1));
			@(negedge clk);
		end
		motion_update_enable = 1'b0;
		in_data_valid = 1'b0;
		// Read taken at the swap edge still answers from the old bank
		in_rden = 1'b1;
		in_read_address = ADDR_WIDTH'($unsigned($random(seed)) % (PARTICLE_NUM + 1));
		@(negedge clk);
		in_rden = 1'b0;
	endtask

	// Count at address 0 and then every slot in order
	task scan_cache;
		repeat (2) @(negedge clk);
		for (int a = 0; a <= PARTICLE_NUM; a++)
		begin
			in_rden = 1'b1;
			in_read_address = ADDR_WIDTH'(a);
			@(negedge clk);
		end
		in_rden = 1'b0;
	endtask

	task report_test(input string name);
		int new_err;
		int new_chk;
		repeat (2) @(negedge clk);
		new_err = err_count - err_mark;
		new_chk = check_count - chk_mark;
		tests_run++;
		if (new_err == 0 && new_chk > 0)
			$display("PASS  %s, %0d checks", name, new_chk);
		else
		begin
			tests_failed++;
			if (new_chk == 0)
				$display("FAIL  %s, no response was compared", name);
			else
				$display("FAIL  %s, %0d of %0d checks wrong", name, new_err, new_chk);
		end
		err_mark = err_count;
		chk_mark = check_count;
	endtask

	initial
	begin
		seed = 32'h9696_dfd3;
		clk = 1'b0;
		rst = 1'b1;
		motion_update_enable = 1'b0;
		in_data = '0;
		in_data_dst_cell = '0;
		in_data_valid = 1'b0;
		in_rden = 1'b0;
		in_read_address = '0;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		cur_cell = '0;
		tests_run = 0;
		tests_failed = 0;
		err_mark = 0;
		chk_mark = 0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		// Reset values, cell id readback and the unmapped offset 0x0C
		read_reg(md_regs_pkg::REG_CELL_ID);
		read_reg(md_regs_pkg::REG_STATUS);
		read_reg(md_regs_pkg::REG_SWAPS);
		cur_cell = md_data_pkg::cell_addr_t'($random(seed));
		write_reg(md_regs_pkg::REG_CELL_ID, md_regs_pkg::axi_data_t'(cur_cell));
		read_reg(md_regs_pkg::REG_CELL_ID);
		read_reg(8'h0C);
		write_reg(8'h0C, $random(seed));
		read_reg(md_regs_pkg::REG_CELL_ID);
		read_reg(md_regs_pkg::REG_STATUS);
		report_test("register reset and access");

		run_update(30, 40);
		scan_cache;
		read_reg(md_regs_pkg::REG_STATUS);
		report_test("first motion update");

		// Old bank still answers while the shadow fills
		run_update(20, 50);
		scan_cache;
		report_test("reads during shadow fill");

		write_reg(md_regs_pkg::REG_STATUS, '0);
		run_update(24, 100);
		scan_cache;
		read_reg(md_regs_pkg::REG_STATUS);
		write_reg(md_regs_pkg::REG_STATUS, '0);
		read_reg(md_regs_pkg::REG_STATUS);
		report_test("shadow overflow and flag clear");

		// Updates that store nothing still swap
		run_update(4, 0);
		run_update(0, 0);
		read_reg(md_regs_pkg::REG_SWAPS);
		repeat (5)
			read_reg(md_regs_pkg::axi_addr_t'(($random(seed) & 3) << 2));
		report_test("swap count and stalled responses");

		$display("Tests %0d, failed %0d, checks %0d, mismatches %0d",
			tests_run, tests_failed, check_count, err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* verif/pos_cache_checker.sv */
// Checker holding a reference model of the cell cache and its registers
`timescale 1ns/1ns

module pos_cache_checker #(
	parameter int PARTICLE_NUM = 16,
	parameter int ADDR_WIDTH = 5
) (
	input  logic clk,
	input  logic rst,
	input  logic motion_update_enable,
	input  md_data_pkg::pos_t in_data,
	input  md_data_pkg::cell_addr_t in_data_dst_cell,
	input  logic in_data_valid,
	input  logic in_rden,
	input  logic [ADDR_WIDTH-1:0] in_read_address,
	input  md_data_pkg::pos_t out_particle_info,
	input  md_regs_pkg::axi_addr_t s_awaddr,
	input  logic s_awvalid,
	input  logic s_awready,
	input  md_regs_pkg::axi_data_t s_wdata,
	input  logic s_wvalid,
	input  logic s_wready,
	input  md_regs_pkg::axi_resp_t s_bresp,
	input  logic s_bvalid,
	input  logic s_bready,
	input  md_regs_pkg::axi_addr_t s_araddr,
	input  logic s_arvalid,
	input  logic s_arready,
	input  md_regs_pkg::axi_data_t s_rdata,
	input  md_regs_pkg::axi_resp_t s_rresp,
	input  logic s_rvalid,
	input  logic s_rready,
	output int err_count,
	output int check_count
);

	// Both banks with slot 0 of each unused
	md_data_pkg::pos_t bank [0:1][0:(1<<ADDR_WIDTH)-1];
	md_data_pkg::cell_addr_t cell_id;
	// Index of the active bank
	logic sel;
	logic upd_d;
	int shadow_count;
	int active_count;
	logic overflow;
	logic [31:0] swaps;
	// Controller pulses as the registers see them one edge late
	logic drop_q;
	logic swap_q;
	// Outstanding particle read and register responses
	logic rd_pend;
	md_data_pkg::pos_t rd_exp;
	md_regs_pkg::axi_data_t r_exp;
	md_regs_pkg::axi_resp_t r_resp_exp;
	md_regs_pkg::axi_resp_t b_resp_exp;
	// Expected bvalid and rvalid
	logic b_pend;
	logic r_pend;
	logic hit;
	logic full;
	logic upd_end;
	logic wr_take;
	logic rd_take;

	initial
	begin
		err_count = 0;
		check_count = 0;
	end

	task check_value(input string name, input logic [95:0] got, input logic [95:0] exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Only the three mapped offsets answer OKAY
	function automatic md_regs_pkg::axi_resp_t resp_for(input md_regs_pkg::axi_addr_t addr);
		if (addr == 8'h00 || addr == 8'h04 || addr == 8'h08)
			return md_regs_pkg::RESP_OKAY;
		return md_regs_pkg::RESP_SLVERR;
	endfunction

	function automatic md_regs_pkg::axi_data_t reg_value(input md_regs_pkg::axi_addr_t addr);
		case (addr)
			8'h00: return {20'd0, cell_id};
			8'h04: return {15'd0, overflow, active_count[15:0]};
			8'h08: return swaps;
			default: return '0;
		endcase
	endfunction

	always @(posedge clk)
	begin
		if (rst)
		begin
			cell_id = '0;
			sel = 1'b0;
			upd_d = 1'b0;
			shadow_count = 0;
			active_count = 0;
			overflow = 1'b0;
			swaps = '0;
			drop_q = 1'b0;
			swap_q = 1'b0;
			rd_pend = 1'b0;
			b_pend = 1'b0;
			r_pend = 1'b0;
		end
		else
		begin
			// Decisions use the state before this edge
			hit = motion_update_enable && in_data_valid && (in_data_dst_cell == cell_id);
			full = (shadow_count == PARTICLE_NUM);
			upd_end = upd_d && !motion_update_enable;
			// Accepts as the protocol allows them
			wr_take = s_awvalid && s_wvalid && !b_pend;
			rd_take = s_arvalid && !r_pend;

			// Handshake outputs
			if (s_awready || wr_take)
				check_value("s_awready", s_awready, wr_take);
			if (s_wready || wr_take)
				check_value("s_wready", s_wready, wr_take);
			if (s_arready || rd_take)
				check_value("s_arready", s_arready, rd_take);
			if (s_bvalid || b_pend)
				check_value("s_bvalid", s_bvalid, b_pend);
			if (s_rvalid || r_pend)
				check_value("s_rvalid", s_rvalid, r_pend);

			// Data for the read taken at the last edge
			if (rd_pend)
				check_value("out_particle_info", out_particle_info, rd_exp);
			// Slots past the count hold stale data
			rd_pend = in_rden && (in_read_address <= active_count);
			if (in_read_address == '0)
			begin
				rd_exp = '0;
				rd_exp[15:0] = active_count[15:0];
			end
			else
				rd_exp = bank[sel][in_read_address];

			if (r_pend && s_rready)
			begin
				check_value("s_rdata", s_rdata, r_exp);
				check_value("s_rresp", s_rresp, r_resp_exp);
				r_pend = 1'b0;
			end
			if (rd_take)
			begin
				r_exp = reg_value(s_araddr);
				r_resp_exp = resp_for(s_araddr);
				r_pend = 1'b1;
			end
			if (b_pend && s_bready)
			begin
				check_value("s_bresp", s_bresp, b_resp_exp);
				b_pend = 1'b0;
			end
			if (wr_take)
			begin
				b_resp_exp = resp_for(s_awaddr);
				b_pend = 1'b1;
			end

			// A fresh drop beats a clear
			if (drop_q)
				overflow = 1'b1;
			else if (wr_take && s_awaddr == 8'h04)
				overflow = 1'b0;
			if (swap_q)
				swaps = swaps + 1;
			if (wr_take && s_awaddr == 8'h00)
				cell_id = s_wdata[11:0];

			drop_q = hit && full;
			swap_q = upd_end;
			if (upd_end)
			begin
				sel = !sel;
				active_count = shadow_count;
				shadow_count = 0;
			end
			else if (hit && !full)
			begin
				// Appended in arrival order from slot 1
				shadow_count++;
				bank[!sel][shadow_count] = in_data;
			end
			upd_d = motion_update_enable;
		end
	end

endmodule

/* logic/pos_cache_cell.sv */
// One cell's double-banked position cache with its configuration registers
`timescale 1ns/1ns

module pos_cache_cell #(
	parameter int PARTICLE_NUM = 220,
	parameter int ADDR_WIDTH = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic motion_update_enable,
	input  md_data_pkg::pos_t in_data,
	input  md_data_pkg::cell_addr_t in_data_dst_cell,
	input  logic in_data_valid,
	input  logic in_rden,
	input  logic [ADDR_WIDTH-1:0] in_read_address,
	output md_data_pkg::pos_t out_particle_info,
	input  md_regs_pkg::axi_addr_t s_awaddr,
	input  logic s_awvalid,
	output logic s_awready,
	input  md_regs_pkg::axi_data_t s_wdata,
	input  logic s_wvalid,
	output logic s_wready,
	output md_regs_pkg::axi_resp_t s_bresp,
	output logic s_bvalid,
	input  logic s_bready,
	input  md_regs_pkg::axi_addr_t s_araddr,
	input  logic s_arvalid,
	output logic s_arready,
	output md_regs_pkg::axi_data_t s_rdata,
	output md_regs_pkg::axi_resp_t s_rresp,
	output logic s_rvalid,
	input  logic s_rready
);

	md_data_pkg::cell_addr_t cell_id;
	logic [15:0] active_count;
	logic swap_pulse;
	logic drop_pulse;
	// Bank ports, address and data shared by both banks
	logic bank0_wr_en;
	logic bank1_wr_en;
	logic [ADDR_WIDTH-1:0] bank_wr_addr;
	md_data_pkg::pos_t bank_wr_data;
	logic bank0_rd_en;
	logic bank1_rd_en;
	logic [ADDR_WIDTH-1:0] bank_rd_addr;
	md_data_pkg::pos_t bank0_rd_data;
	md_data_pkg::pos_t bank1_rd_data;

	cell_cfg_axil u_cfg (
		.clk(clk),
		.rst(rst),
		.s_awaddr(s_awaddr),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.s_wdata(s_wdata),
		.s_wvalid(s_wvalid),
		.s_wready(s_wready),
		.s_bresp(s_bresp),
		.s_bvalid(s_bvalid),
		.s_bready(s_bready),
		.s_araddr(s_araddr),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata(s_rdata),
		.s_rresp(s_rresp),
		.s_rvalid(s_rvalid),
		.s_rready(s_rready),
		.cell_id(cell_id),
		.active_count(active_count),
		.swap_pulse(swap_pulse),
		.drop_pulse(drop_pulse)
	);

	pos_cache_ctrl #(
		.PARTICLE_NUM(PARTICLE_NUM),
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.motion_update_enable(motion_update_enable),
		.in_data(in_data),
		.in_data_dst_cell(in_data_dst_cell),
		.in_data_valid(in_data_valid),
		.in_rden(in_rden),
		.in_read_address(in_read_address),
		.cell_id(cell_id),
		.out_particle_info(out_particle_info),
		.active_count(active_count),
		.swap_pulse(swap_pulse),
		.drop_pulse(drop_pulse),
		.bank0_wr_en(bank0_wr_en),
		.bank1_wr_en(bank1_wr_en),
		.bank_wr_addr(bank_wr_addr),
		.bank_wr_data(bank_wr_data),
		.bank0_rd_en(bank0_rd_en),
		.bank1_rd_en(bank1_rd_en),
		.bank_rd_addr(bank_rd_addr),
		.bank0_rd_data(bank0_rd_data),
		.bank1_rd_data(bank1_rd_data)
	);

	// Active after reset
	pos_bank #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_bank0 (
		.clk(clk),
		.wr_en(bank0_wr_en),
		.wr_addr(bank_wr_addr),
		.wr_data(bank_wr_data),
		.rd_en(bank0_rd_en),
		.rd_addr(bank_rd_addr),
		.rd_data(bank0_rd_data)
	);

	// Shadow after reset
	pos_bank #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_bank1 (
		.clk(clk),
		.wr_en(bank1_wr_en),
		.wr_addr(bank_wr_addr),
		.wr_data(bank_wr_data),
		.rd_en(bank1_rd_en),
		.rd_addr(bank_rd_addr),
		.rd_data(bank1_rd_data)
	);

endmodule

/* logic/cell_cfg_axil.sv */
// AXI4-Lite register block for cell id, sticky overflow flag and swap counter
`timescale 1ns/1ns

module cell_cfg_axil (
	input  logic clk,
	input  logic rst,
	input  md_regs_pkg::axi_addr_t s_awaddr,
	input  logic s_awvalid,
	output logic s_awready,
	input  md_regs_pkg::axi_data_t s_wdata,
	input  logic s_wvalid,
	output logic s_wready,
	output md_regs_pkg::axi_resp_t s_bresp,
	output logic s_bvalid,
	input  logic s_bready,
	input  md_regs_pkg::axi_addr_t s_araddr,
	input  logic s_arvalid,
	output logic s_arready,
	output md_regs_pkg::axi_data_t s_rdata,
	output md_regs_pkg::axi_resp_t s_rresp,
	output logic s_rvalid,
	input  logic s_rready,
	output md_data_pkg::cell_addr_t cell_id,
	input  logic [15:0] active_count,
	input  logic swap_pulse,
	input  logic drop_pulse
);

	logic wr_fire;
	logic rd_fire;
	logic overflow;
	md_regs_pkg::axi_data_t swap_cnt;
	md_regs_pkg::axi_data_t rd_word;
	md_regs_pkg::axi_resp_t rd_resp;
	md_regs_pkg::axi_resp_t wr_resp;

	// Address and data taken together, one write outstanding
	assign wr_fire = s_awvalid && s_wvalid && !s_bvalid;
	assign s_awready = wr_fire;
	assign s_wready = wr_fire;
	// One read outstanding
	assign rd_fire = s_arvalid && !s_rvalid;
	assign s_arready = rd_fire;

	// Write decode, a write to SWAPS is accepted and ignored
	always_comb
	begin
		case (s_awaddr)
			md_regs_pkg::REG_CELL_ID,
			md_regs_pkg::REG_STATUS,
			md_regs_pkg::REG_SWAPS:
				wr_resp = md_regs_pkg::RESP_OKAY;
			default:
				wr_resp = md_regs_pkg::RESP_SLVERR;
		endcase
	end

	// Read mux, unmapped returns zero
	always_comb
	begin
		rd_word = '0;
		rd_resp = md_regs_pkg::RESP_OKAY;
		case (s_araddr)
			md_regs_pkg::REG_CELL_ID:
				rd_word = md_regs_pkg::axi_data_t'(cell_id);
			md_regs_pkg::REG_STATUS:
				rd_word = {15'd0, overflow, active_count};
			md_regs_pkg::REG_SWAPS:
				rd_word = swap_cnt;
			default:
				rd_resp = md_regs_pkg::RESP_SLVERR;
		endcase
	end

	// Response valids, held until the master takes them
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s_bvalid <= 1'b0;
			s_rvalid <= 1'b0;
		end
		else
		begin
			if (wr_fire)
				s_bvalid <= 1'b1;
			else if (s_bready)
				s_bvalid <= 1'b0;
			if (rd_fire)
				s_rvalid <= 1'b1;
			else if (s_rready)
				s_rvalid <= 1'b0;
		end
	end

	// Response payload
	always_ff @(posedge clk)
	begin
		if (wr_fire)
			s_bresp <= wr_resp;
		if (rd_fire)
		begin
			s_rdata <= rd_word;
			s_rresp <= rd_resp;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cell_id <= '0;
			overflow <= 1'b0;
			swap_cnt <= '0;
		end
		else
		begin
			if (wr_fire && s_awaddr == md_regs_pkg::REG_CELL_ID)
				cell_id <= md_data_pkg::cell_addr_t'(s_wdata);
			// A new drop wins over a clear on the same edge
			if (drop_pulse)
				overflow <= 1'b1;
			else if (wr_fire && s_awaddr == md_regs_pkg::REG_STATUS)
				overflow <= 1'b0;
			// Wraps at 2^32
			if (swap_pulse)
				swap_cnt <= swap_cnt + 1'b1;
		end
	end

endmodule

/* logic/pos_cache_ctrl.sv */
// Position cache controller doing cell filtering, shadow append and bank swap
`timescale 1ns/1ns

module pos_cache_ctrl #(
	parameter int PARTICLE_NUM = 220,
	parameter int ADDR_WIDTH = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic motion_update_enable,
	input  md_data_pkg::pos_t in_data,
	input  md_data_pkg::cell_addr_t in_data_dst_cell,
	input  logic in_data_valid,
	input  logic in_rden,
	input  logic [ADDR_WIDTH-1:0] in_read_address,
	input  md_data_pkg::cell_addr_t cell_id,
	output md_data_pkg::pos_t out_particle_info,
	output logic [15:0] active_count,
	output logic swap_pulse,
	output logic drop_pulse,
	output logic bank0_wr_en,
	output logic bank1_wr_en,
	output logic [ADDR_WIDTH-1:0] bank_wr_addr,
	output md_data_pkg::pos_t bank_wr_data,
	output logic bank0_rd_en,
	output logic bank1_rd_en,
	output logic [ADDR_WIDTH-1:0] bank_rd_addr,
	input  md_data_pkg::pos_t bank0_rd_data,
	input  md_data_pkg::pos_t bank1_rd_data
);

	// Low selects bank 0 as the active bank
	logic bank_sel;
	// Update enable from the last edge, for end detection
	logic update_d;
	logic [ADDR_WIDTH-1:0] shadow_count;
	// Read state captured at the read edge
	logic rd_sel_q;
	logic rd_zero_q;
	logic [15:0] rd_count_q;
	logic hit;
	logic full;
	logic append;
	logic update_end;

	// Arrival bound for this cell
	assign hit = motion_update_enable && in_data_valid && (in_data_dst_cell == cell_id);
	assign full = (shadow_count == ADDR_WIDTH'(PARTICLE_NUM));
	assign append = hit && !full;
	// First edge seeing enable low after high
	assign update_end = update_d && !motion_update_enable;

	// Writes go to the bank that is not selected
	assign bank0_wr_en = append && bank_sel;
	assign bank1_wr_en = append && !bank_sel;
	// Slot 0 is the count, so particles start at 1
	assign bank_wr_addr = shadow_count + 1'b1;
	assign bank_wr_data = in_data;

	// Only the active bank is read
	assign bank0_rd_en = in_rden && !bank_sel;
	assign bank1_rd_en = in_rden && bank_sel;
	assign bank_rd_addr = in_read_address;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bank_sel <= 1'b0;
			update_d <= 1'b0;
			shadow_count <= '0;
			active_count <= '0;
			swap_pulse <= 1'b0;
			drop_pulse <= 1'b0;
		end
		else
		begin
			update_d <= motion_update_enable;
			swap_pulse <= update_end;
			// Shadow bank full, arrival lost
			drop_pulse <= hit && full;
			if (update_end)
			begin
				bank_sel <= !bank_sel;
				active_count <= 16'(shadow_count);
				shadow_count <= '0;
			end
			else if (append)
				shadow_count <= shadow_count + 1'b1;
		end
	end

	// Select and address-0 flag follow the read, so a swap in flight
	// still returns old-bank data
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_sel_q <= 1'b0;
			rd_zero_q <= 1'b0;
		end
		else if (in_rden)
		begin
			rd_sel_q <= bank_sel;
			rd_zero_q <= (in_read_address == '0);
		end
	end

	// Count as it was at the read edge
	always_ff @(posedge clk)
	begin
		if (in_rden)
			rd_count_q <= active_count;
	end

	// Output mux
	always_comb
	begin
		if (rd_zero_q)
			out_particle_info = md_data_pkg::pos_t'(rd_count_q);
		else if (rd_sel_q)
			out_particle_info = bank1_rd_data;
		else
			out_particle_info = bank0_rd_data;
	end

endmodule

/* logic/pos_bank.sv */
// Position memory bank with synchronous write and one-cycle registered read
`timescale 1ns/1ns

module pos_bank #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic clk,
	input  logic wr_en,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  md_data_pkg::pos_t wr_data,
	input  logic rd_en,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output md_data_pkg::pos_t rd_data
);

	// Entry 0 unused, particles live at 1 up to the count
	md_data_pkg::pos_t mem [0:(1<<ADDR_WIDTH)-1];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Output register holds its word while rd_en is low
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

/* logic/md_regs_pkg.sv */
// Register map and AXI4-Lite types of the cell configuration block
package md_regs_pkg;

	typedef logic [7:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0] axi_resp_t;

	// Response codes
	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// Cell address in bits 11:0
	localparam axi_addr_t REG_CELL_ID = 8'h00;
	// Active count in 15:0, sticky overflow in 16, cleared by any write
	localparam axi_addr_t REG_STATUS = 8'h04;
	// Completed swaps, read only
	localparam axi_addr_t REG_SWAPS = 8'h08;

endpackage

/* logic/md_data_pkg.sv */
// Particle position and cell address formats shared by the position cache
package md_data_pkg;

	// One fixed-point coordinate
	typedef logic [31:0] coord_t;

	// Position word, MSB to LSB is z, y, x
	typedef logic [3*$bits(coord_t)-1:0] pos_t;

	// Cell index along one axis
	typedef logic [3:0] cell_idx_t;

	// Full cell address, MSB to LSB is x, y, z
	typedef logic [3*$bits(cell_idx_t)-1:0] cell_addr_t;

endpackage
